// File: Bender.yml
package:
  name: fp_add

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fp_format_pkg.sv
      - verilog/fp_op_pkg.sv
      - verilog/fp_stage_if.sv
      - verilog/fp_unpack_swap.sv
      - verilog/align_significands.sv
      - verilog/sig_add_normalize.sv
      - verilog/round_pack.sv
      - verilog/fp_add_top.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/fp_add_tb.sv

// File: project.f
+incdir+verilog
+incdir+test
verilog/fp_format_pkg.sv
verilog/fp_op_pkg.sv
verilog/fp_stage_if.sv
verilog/fp_unpack_swap.sv
verilog/align_significands.sv
verilog/sig_add_normalize.sv
verilog/round_pack.sv
verilog/fp_add_top.sv
test/fp_add_tb.sv

// File: test/fp_add_ref.svh
// adder reference model: exact sum in a 64-bit window, nearest-even rounding, flush rules
`ifndef FP_ADD_REF_SVH
`define FP_ADD_REF_SVH

function automatic logic [31:0] fp_add_ref(input logic [31:0] x, input logic [31:0] y,
                                           input logic subtract);
    logic        sx;
    logic        sy;
    logic [7:0]  ex;
    logic [7:0]  ey;
    logic [23:0] mx;
    logic [23:0] my;
    logic        x_big;
    logic        s_res;
    logic        sticky;
    logic [63:0] wide_big;
    logic [63:0] wide_small;
    logic [63:0] shifted;
    logic [64:0] total;
    logic [64:0] rest;
    logic [64:0] half;
    logic [24:0] mant;
    int          diff;
    int          top;
    int          e_res;
    sx = x[31];
    // subtraction is addition with the second sign flipped
    sy = y[31] ^ subtract;
    ex = x[30:23];
    ey = y[30:23];
    if ((ex == 8'hff && x[22:0] != 0) || (ey == 8'hff && y[22:0] != 0)) begin
        return 32'h7fc00000;
    end
    if (ex == 8'hff && ey == 8'hff) begin
        return (sx == sy) ? {sx, 8'hff, 23'd0} : 32'h7fc00000;
    end
    if (ex == 8'hff) begin
        return {sx, 8'hff, 23'd0};
    end
    if (ey == 8'hff) begin
        return {sy, 8'hff, 23'd0};
    end
    // exponent 0 reads as zero, subnormals too
    if (ex == 0 && ey == 0) begin
        return {sx & sy, 31'd0};
    end
    mx = (ex == 0) ? 24'd0 : {1'b1, x[22:0]};
    my = (ey == 0) ? 24'd0 : {1'b1, y[22:0]};
    x_big = ({ex, mx} >= {ey, my});
    s_res = x_big ? sx : sy;
    e_res = x_big ? int'(ex) : int'(ey);
    diff  = x_big ? int'(ex) - int'(ey) : int'(ey) - int'(ex);
    // 40 spare bits below the larger significand
    wide_big   = {x_big ? mx : my, 40'd0};
    wide_small = {x_big ? my : mx, 40'd0};
    shifted    = wide_small >> diff;
    // anything below the window only counts as sticky
    sticky     = ((shifted << diff) != wide_small);
    shifted[0] = shifted[0] | sticky;
    if (sx == sy) begin
        total = {1'b0, wide_big} + {1'b0, shifted};
    end else begin
        total = {1'b0, wide_big} - {1'b0, shifted};
    end
    if (total == 0) begin
        return 32'h0;
    end
    top = 0;
    for (int k = 0; k < 65; k++) begin
        if (total[k]) begin
            top = k;
        end
    end
    // bit 63 carries the larger operand's exponent
    e_res = e_res + top - 63;
    mant  = 25'(total >> (top - 23));
    rest  = total & ((65'd1 << (top - 23)) - 65'd1);
    half  = 65'd1 << (top - 24);
    if (rest > half || (rest == half && mant[0])) begin
        mant = mant + 25'd1;
    end
    if (mant[24]) begin
        mant  = mant >> 1;
        e_res = e_res + 1;
    end
    if (e_res > 254) begin
        return {s_res, 8'hff, 23'd0};
    end
    if (e_res < 1) begin
        return {s_res, 31'd0};
    end
    return {s_res, e_res[7:0], mant[22:0]};
endfunction

`endif

// File: test/fp_add_tb.sv
// adder testbench: directed, random and back-pressure streams checked against a reference
`timescale 1ns/1ps
`default_nettype none

`include "fp_cfg.svh"

module fp_add_tb import fp_format_pkg::*, fp_op_pkg::*; ();

    `include "fp_add_ref.svh"

    localparam int RESET_CYCLES   = 10;
    localparam int N_DIRECTED     = 30;
    localparam int N_RANDOM       = 300;
    localparam int N_BACKPRESSURE = 300;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    float32_t a;
    float32_t b;
    op_e      op;
    logic     out_valid;
    logic     out_ready;
    float32_t result;

    // expected results and accept cycles, in acceptance order
    float32_t expect_q[$];
    int       accept_q[$];
    int       cycle_count;
    int       checked;
    int       errors;
    int       test_errors;
    int       test_ops;
    logic     check_latency;
    logic     backpressure;
    integer   seed;
    integer   ready_seed;

    fp_add_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .op        (op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output side, random stalls only during back-pressure
    always @(posedge clk) begin
        integer ready_draw;
        #0.5;
        ready_draw = $random(ready_seed);
        out_ready  = backpressure ? (ready_draw[1:0] == 2'b00) : 1'b1;
    end

    // scoreboard, all handshakes sampled at the edge
    always @(posedge clk) begin
        float32_t want;
        int       latency;
        cycle_count = cycle_count + 1;
        if (rst_n) begin
            // only a full pipeline may stall the input
            if (!in_ready && (expect_q.size() != 4)) begin
                $display("[%0t] in_ready low with %0d items in flight", $time, expect_q.size());
                errors++;
            end
            if (check_latency && !in_ready) begin
                $display("[%0t] in_ready low while out_ready was held high", $time);
                errors++;
            end
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("[%0t] result delivered with no operation outstanding", $time);
                    errors++;
                end else begin
                    want    = expect_q.pop_front();
                    latency = cycle_count - accept_q.pop_front();
                    checked++;
                    if (result !== want) begin
                        $display("CHECK FAILED [%0t] result expected %h got %h",
                                 $time, want, result);
                        errors++;
                    end
                    if (check_latency && (latency != 4)) begin
                        $display("CHECK FAILED [%0t] latency expected 4 got %0d", $time, latency);
                        errors++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                expect_q.push_back(fp_add_ref(a, b, op == FP_SUB));
                accept_q.push_back(cycle_count);
            end
        end
    end

    // hold one operation until the DUT takes it
    task automatic send(input float32_t x, input float32_t y, input op_e kind);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        op       = kind;
        do begin
            @(posedge clk);
        end while (!in_ready);
        #0.5;
        in_valid = 1'b0;
        test_ops++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic drain();
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        #0.5;
    endtask

    task automatic close_test(input string name);
        drain();
        $display("[%0t] %s: %0d ops, %0d errors", $time, name, test_ops, errors - test_errors);
        test_errors = errors;
        test_ops    = 0;
    endtask

    initial begin
        float32_t x;
        float32_t y;
        integer   draw;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        a             = '0;
        b             = '0;
        op            = FP_ADD;
        out_ready     = 1'b1;
        cycle_count   = 0;
        checked       = 0;
        errors        = 0;
        test_errors   = 0;
        test_ops      = 0;
        check_latency = 1'b0;
        backpressure  = 1'b0;
        seed          = 32'h2246;
        ready_seed    = 32'h2246;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        idle(2);

        // equal exponents, shifts 1 to 3, sticky deciding ties
        send(32'h3f800000, 32'h3f800000, FP_ADD);
        send(32'h3fc00000, 32'h40200000, FP_ADD);
        send(32'h3f800001, 32'h3e800001, FP_ADD);
        send(32'h3f800000, 32'h3e000000, FP_ADD);
        send(32'h3f800000, 32'h33800000, FP_ADD);
        send(32'h3f800000, 32'h33800001, FP_ADD);
        send(32'h3f800001, 32'h33800000, FP_ADD);
        send(32'h3f800000, 32'h33000000, FP_SUB);
        send(32'h41800000, 32'h3f800001, FP_SUB);
        close_test("test 1 directed normal sums");

        // cancellation and signed zeros
        send(32'h40490fdb, 32'h40490fdb, FP_SUB);
        send(32'hc0490fdb, 32'h40490fdb, FP_ADD);
        send(32'h3f800001, 32'h3f800000, FP_SUB);
        send(32'h3f7fffff, 32'h3f7ffffe, FP_SUB);
        send(32'h4b000001, 32'h4b000000, FP_SUB);
        send(32'h00000000, 32'h00000000, FP_ADD);
        send(32'h80000000, 32'h80000000, FP_ADD);
        send(32'h80000000, 32'h00000000, FP_SUB);
        send(32'h00000000, 32'h80000000, FP_ADD);
        close_test("test 2 cancellation and zero");

        // nan, infinity, overflow, subnormal flush, flushed results
        send(32'h7fc00000, 32'h3f800000, FP_ADD);
        send(32'h3f800000, 32'h7f800001, FP_ADD);
        send(32'h7f800000, 32'h7f800000, FP_SUB);
        send(32'h7f800000, 32'hff800000, FP_ADD);
        send(32'hff800000, 32'h42000000, FP_ADD);
        send(32'h7f800000, 32'h7f800000, FP_ADD);
        send(32'h7f7fffff, 32'h7f7fffff, FP_ADD);
        send(32'hff7fffff, 32'h7f7fffff, FP_SUB);
        send(32'h00000001, 32'h3f800000, FP_ADD);
        send(32'h80400000, 32'h00000000, FP_ADD);
        send(32'h00800000, 32'h00800001, FP_SUB);
        send(32'h00c00000, 32'h00800000, FP_SUB);
        close_test("test 3 special values");

        // back-to-back stream, latency and throughput watched
        check_latency = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            x    = $random(seed);
            y    = $random(seed);
            draw = $random(seed);
            // close exponents for half the pairs so the operands interact
            if (draw[0]) begin
                y[`FP_FRAC_W +: `FP_EXP_W] = x[`FP_FRAC_W +: `FP_EXP_W] + {5'd0, draw[4:2]};
            end
            send(x, y, draw[1] ? FP_SUB : FP_ADD);
        end
        close_test("test 4 random stream");
        check_latency = 1'b0;

        // random stalls on both sides
        backpressure = 1'b1;
        for (int n = 0; n < N_BACKPRESSURE; n++) begin
            x    = $random(seed);
            y    = $random(seed);
            draw = $random(seed);
            if (draw[0]) begin
                y[`FP_FRAC_W +: `FP_EXP_W] = x[`FP_FRAC_W +: `FP_EXP_W] - {5'd0, draw[4:2]};
            end
            if (draw[5]) begin
                idle(draw[7:6]);
            end
            send(x, y, draw[1] ? FP_SUB : FP_ADD);
        end
        backpressure = 1'b0;
        close_test("test 5 back-pressure");

        $display("[%0t] %0d results checked, %0d errors", $time, checked, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // generous bound, 20 cycles per operation plus slack
    initial begin
        repeat (RESET_CYCLES + (N_DIRECTED + N_RANDOM + N_BACKPRESSURE) * 20 + 200) begin
            @(posedge clk);
        end
        $display("[%0t] watchdog expired, outputs stopped arriving", $time);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/align_significands.sv
// alignment stage: shifts the smaller significand right and folds lost bits into sticky
`timescale 1ns/1ps
`default_nettype none

`include "fp_cfg.svh"

module align_significands import fp_format_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    fp_stage_if.dst i,
    fp_stage_if.src o
);

    sig_t shifted;
    sig_t lost_mask;
    logic sticky;
    sig_t aligned;

    always_comb begin
        shifted   = i.sig_b >> i.shift;
        // ones over every bit position that falls off the bottom
        lost_mask = ~({`FP_SIG_W{1'b1}} << i.shift);
        sticky    = |(i.sig_b & lost_mask);
        aligned   = shifted;
        // up to 3 places only the zero grs bits drop out, nothing to keep
        if (i.shift > `FP_GRS_W) begin
            aligned[0] = shifted[0] | sticky;
        end
    end

    assign i.ready = !o.valid || o.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o.valid <= 1'b0;
        end else if (i.ready) begin
            o.valid <= i.valid;
        end
    end

    // larger operand and the rest pass straight on
    always_ff @(posedge clk) begin
        if (i.ready && i.valid) begin
            o.sign    <= i.sign;
            o.exp     <= i.exp;
            o.sig_a   <= i.sig_a;
            o.sig_b   <= aligned;
            // shift spent here
            o.shift   <= '0;
            o.eff_sub <= i.eff_sub;
            o.cls     <= i.cls;
            o.special <= i.special;
        end
    end

    // operand order from unpack must survive alignment, so subtract never borrows
    a_aligned_order: assert property (@(posedge clk) disable iff (!rst_n)
        o.valid |-> (o.sig_b <= o.sig_a));

endmodule

`default_nettype wire

// File: verilog/fp_add_top.sv
// single-precision adder/subtractor top: four pipelined stages behind a valid/ready stream
`timescale 1ns/1ps
`default_nettype none

module fp_add_top import fp_format_pkg::*, fp_op_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  float32_t a,
    input  float32_t b,
    input  op_e      op,
    output logic     out_valid,
    input  logic     out_ready,
    output float32_t result
);

    // links between the stages
    fp_stage_if s1 ();
    fp_stage_if s2 ();
    fp_stage_if s3 ();

    // stage 1, unpack and order
    fp_unpack_swap u_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .a        (a),
        .b        (b),
        .op       (op),
        .o        (s1.src)
    );

    // stage 2, align smaller operand
    align_significands u_align (
        .clk   (clk),
        .rst_n (rst_n),
        .i     (s1.dst),
        .o     (s2.src)
    );

    // stage 3, add or subtract then normalize
    sig_add_normalize u_add_norm (
        .clk   (clk),
        .rst_n (rst_n),
        .i     (s2.dst),
        .o     (s3.src)
    );

    // stage 4, round and pack
    round_pack u_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .i         (s3.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: verilog/fp_cfg.svh
// single-precision format configuration: field widths, guard bits and exponent bias
`ifndef FP_CFG_SVH
`define FP_CFG_SVH

// biased exponent field
`define FP_EXP_W 8

// stored fraction, hidden bit not included
`define FP_FRAC_W 23

// guard, round and sticky below the fraction
`define FP_GRS_W 3

// exponent bias, twice this is the largest finite exponent
`define FP_BIAS 127

// working significand: hidden bit + fraction + grs (27)
`define FP_SIG_W (1 + `FP_FRAC_W + `FP_GRS_W)

`endif

// File: verilog/fp_format_pkg.sv
// floating-point format types: IEEE word, exponent, significand and shift vectors
`default_nettype none

`include "fp_cfg.svh"

package fp_format_pkg;

    // sign, exponent, fraction
    typedef logic [`FP_EXP_W+`FP_FRAC_W:0] float32_t;

    // biased exponent as stored
    typedef logic [`FP_EXP_W-1:0] exp_t;

    // signed working exponent
    // two extra bits so normalization may run below 1 or past 254
    typedef logic signed [`FP_EXP_W+1:0] exp_wide_t;

    // hidden bit, fraction, guard, round, sticky
    typedef logic [`FP_SIG_W-1:0] sig_t;

    // alignment distance, saturates at the significand width
    typedef logic [`FP_EXP_W-1:0] shift_t;

endpackage

`default_nettype wire

// File: verilog/fp_op_pkg.sv
// floating-point operation types: operation select, result class and canonical quiet NaN
`default_nettype none

`include "fp_cfg.svh"

package fp_op_pkg;

    import fp_format_pkg::*;

    typedef enum logic {
        FP_ADD = 1'b0,
        FP_SUB = 1'b1
    } op_e;

    // class of the pending result as decided at unpack
    // a normal result may still collapse to zero or overflow downstream
    typedef enum logic [1:0] {
        CLS_NORMAL = 2'd0,
        CLS_ZERO   = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } class_e;

    // positive, all-ones exponent, only the quiet bit of the fraction (0x7fc00000)
    localparam float32_t FP_QNAN = {1'b0, {`FP_EXP_W{1'b1}}, 1'b1, {(`FP_FRAC_W-1){1'b0}}};

endpackage

`default_nettype wire

// File: verilog/fp_stage_if.sv
// pipeline stage link: valid/ready handshake with the adder's working payload
`timescale 1ns/1ps
`default_nettype none

interface fp_stage_if import fp_format_pkg::*, fp_op_pkg::*; ();

    // handshake, transfer on a clock edge with both high
    logic      valid;
    logic      ready;

    // working payload, stable while valid and not ready
    logic      sign;
    exp_wide_t exp;
    // larger significand
    sig_t      sig_a;
    // smaller significand, or the result after the add stage
    sig_t      sig_b;
    shift_t    shift;
    logic      eff_sub;
    class_e    cls;
    // finished word for zero, inf and nan classes
    float32_t  special;

    modport src (
        output valid, sign, exp, sig_a, sig_b, shift, eff_sub, cls, special,
        input  ready
    );

    modport dst (
        input  valid, sign, exp, sig_a, sig_b, shift, eff_sub, cls, special,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/fp_unpack_swap.sv
// unpack stage: flushes subnormals, classifies specials, orders operands, finds the shift
`timescale 1ns/1ps
`default_nettype none

`include "fp_cfg.svh"

module fp_unpack_swap import fp_format_pkg::*, fp_op_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  float32_t a,
    input  float32_t b,
    input  op_e      op,
    fp_stage_if.src  o
);

    localparam exp_t EXP_ALL_ONES = '1;

    // field views, b sign already folded with the operation
    logic                  sign_a;
    logic                  sign_b;
    exp_t                  exp_a;
    exp_t                  exp_b;
    logic [`FP_FRAC_W-1:0] frac_a;
    logic [`FP_FRAC_W-1:0] frac_b;
    logic                  zero_a;
    logic                  zero_b;
    logic                  inf_a;
    logic                  inf_b;
    logic                  nan_a;
    logic                  nan_b;
    sig_t                  full_a;
    sig_t                  full_b;
    logic                  a_big;
    logic                  eff_sub;
    exp_t                  exp_big;
    exp_t                  exp_small;
    exp_t                  exp_diff;
    shift_t                nxt_shift;
    class_e                nxt_cls;
    float32_t              nxt_special;

    always_comb begin
        sign_a  = a[`FP_EXP_W+`FP_FRAC_W];
        sign_b  = b[`FP_EXP_W+`FP_FRAC_W] ^ (op == FP_SUB);
        exp_a   = a[`FP_FRAC_W +: `FP_EXP_W];
        exp_b   = b[`FP_FRAC_W +: `FP_EXP_W];
        frac_a  = a[`FP_FRAC_W-1:0];
        frac_b  = b[`FP_FRAC_W-1:0];
        // zero exponent also covers subnormals, flushed to signed zero
        zero_a  = (exp_a == '0);
        zero_b  = (exp_b == '0);
        inf_a   = (exp_a == EXP_ALL_ONES) && (frac_a == '0);
        inf_b   = (exp_b == EXP_ALL_ONES) && (frac_b == '0);
        nan_a   = (exp_a == EXP_ALL_ONES) && (frac_a != '0);
        nan_b   = (exp_b == EXP_ALL_ONES) && (frac_b != '0);
        eff_sub = sign_a ^ sign_b;
        // hidden bit on top, grs cleared
        full_a  = zero_a ? '0 : {1'b1, frac_a, {`FP_GRS_W{1'b0}}};
        full_b  = zero_b ? '0 : {1'b1, frac_b, {`FP_GRS_W{1'b0}}};
        // magnitude order on exponent then fraction
        a_big   = zero_b || (!zero_a &&
                  (a[`FP_EXP_W+`FP_FRAC_W-1:0] >= b[`FP_EXP_W+`FP_FRAC_W-1:0]));
        exp_big   = a_big ? exp_a : exp_b;
        exp_small = a_big ? exp_b : exp_a;
        exp_diff  = exp_big - exp_small;
        // past the full width everything lands in sticky anyway
        nxt_shift = (exp_diff > `FP_SIG_W) ? shift_t'(`FP_SIG_W) : exp_diff;

        // nan wins, then inf, then the both-zero case
        if (nan_a || nan_b || (inf_a && inf_b && eff_sub)) begin
            nxt_cls     = CLS_NAN;
            nxt_special = FP_QNAN;
        end else if (inf_a || inf_b) begin
            nxt_cls     = CLS_INF;
            nxt_special = {inf_a ? sign_a : sign_b, EXP_ALL_ONES, {`FP_FRAC_W{1'b0}}};
        end else if (zero_a && zero_b) begin
            // unlike signs give +0
            nxt_cls     = CLS_ZERO;
            nxt_special = {sign_a & sign_b, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
        end else begin
            nxt_cls     = CLS_NORMAL;
            nxt_special = '0;
        end
    end

    // single output register, refills when empty or drained
    assign in_ready = !o.valid || o.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o.valid <= 1'b0;
        end else if (in_ready) begin
            o.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            o.sign    <= a_big ? sign_a : sign_b;
            o.exp     <= exp_wide_t'(exp_big);
            o.sig_a   <= a_big ? full_a : full_b;
            o.sig_b   <= a_big ? full_b : full_a;
            o.shift   <= nxt_shift;
            o.eff_sub <= eff_sub;
            o.cls     <= nxt_cls;
            o.special <= nxt_special;
        end
    end

    // align stage relies on the shift staying inside the significand
    a_shift_range: assert property (@(posedge clk) disable iff (!rst_n)
        o.valid |-> (o.shift <= shift_t'(`FP_SIG_W)));

endmodule

`default_nettype wire

// File: verilog/round_pack.sv
// round stage: nearest-even rounding, overflow and underflow handling, IEEE packing
`timescale 1ns/1ps
`default_nettype none

`include "fp_cfg.svh"

module round_pack import fp_format_pkg::*, fp_op_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    fp_stage_if.dst  i,
    output logic     out_valid,
    input  logic     out_ready,
    output float32_t result
);

    localparam exp_t EXP_ALL_ONES = '1;

    logic                  lsb;
    logic                  guard;
    logic                  round_bit;
    logic                  sticky;
    logic                  round_up;
    // hidden bit + fraction, one spare bit on top for the rounding carry
    logic [`FP_FRAC_W+1:0] mant;
    logic                  carry;
    exp_wide_t             exp_r;
    logic [`FP_FRAC_W-1:0] frac_r;
    float32_t              nxt_result;

    always_comb begin
        lsb       = i.sig_b[`FP_GRS_W];
        guard     = i.sig_b[`FP_GRS_W-1];
        round_bit = i.sig_b[`FP_GRS_W-2];
        sticky    = i.sig_b[0];
        // above half, or exactly half with an odd lsb
        round_up  = guard & (round_bit | sticky | lsb);
        mant      = {1'b1 & 1'b0, i.sig_b[`FP_SIG_W-1:`FP_GRS_W]} + round_up;
        // all-ones fraction rolled over to 10.000..
        carry     = mant[`FP_FRAC_W+1];
        exp_r     = i.exp + exp_wide_t'(carry);
        // a rollover leaves the low fraction bits all zero
        frac_r    = mant[`FP_FRAC_W-1:0];

        if (i.cls != CLS_NORMAL) begin
            nxt_result = i.special;
        end else if (exp_r > exp_wide_t'(2 * `FP_BIAS)) begin
            // overflow to signed infinity
            nxt_result = {i.sign, EXP_ALL_ONES, {`FP_FRAC_W{1'b0}}};
        end else if (exp_r < exp_wide_t'(1)) begin
            // no subnormal outputs, flush to signed zero
            nxt_result = {i.sign, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
        end else begin
            nxt_result = {i.sign, exp_t'(exp_r), frac_r};
        end
    end

    // last register, held while the consumer stalls
    assign i.ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (i.ready) begin
            out_valid <= i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i.ready && i.valid) begin
            result <= nxt_result;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sig_add_normalize.sv
// add stage: adds or subtracts the aligned significands and normalizes the result
`timescale 1ns/1ps
`default_nettype none

`include "fp_cfg.svh"

module sig_add_normalize import fp_format_pkg::*, fp_op_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    fp_stage_if.dst i,
    fp_stage_if.src o
);

    // extra top bit catches the add carry
    logic [`FP_SIG_W:0] sum;
    logic [4:0]         lead;
    sig_t               norm_sig;
    exp_wide_t          norm_exp;
    class_e             nxt_cls;
    float32_t           nxt_special;

    // leading zero count over the working significand
    function automatic logic [4:0] count_lead_zeros(input sig_t v);
        logic [4:0] n;
        logic       seen;
        n    = '0;
        seen = 1'b0;
        for (int k = `FP_SIG_W - 1; k >= 0; k--) begin
            if (v[k]) begin
                seen = 1'b1;
            end else if (!seen) begin
                n = n + 5'd1;
            end
        end
        return n;
    endfunction

    always_comb begin
        // sig_a is never smaller, so the difference stays positive
        if (i.eff_sub) begin
            sum = {1'b0, i.sig_a} - {1'b0, i.sig_b};
        end else begin
            sum = {1'b0, i.sig_a} + {1'b0, i.sig_b};
        end
        lead = count_lead_zeros(sum[`FP_SIG_W-1:0]);

        if (sum[`FP_SIG_W]) begin
            // carry out, one place right, lowest bit kept in sticky
            norm_sig = {sum[`FP_SIG_W:2], sum[1] | sum[0]};
            norm_exp = i.exp + exp_wide_t'(1);
        end else begin
            // cancellation, pull the leading one up to the hidden bit
            norm_sig = sum[`FP_SIG_W-1:0] << lead;
            norm_exp = i.exp - exp_wide_t'(lead);
        end

        // exact zero from a normal pair is +0
        if ((i.cls == CLS_NORMAL) && (sum == '0)) begin
            nxt_cls     = CLS_ZERO;
            nxt_special = '0;
        end else begin
            nxt_cls     = i.cls;
            nxt_special = i.special;
        end
    end

    assign i.ready = !o.valid || o.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o.valid <= 1'b0;
        end else if (i.ready) begin
            o.valid <= i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i.ready && i.valid) begin
            o.sign    <= i.sign;
            o.exp     <= norm_exp;
            // result travels in sig_b from here on
            o.sig_a   <= '0;
            o.sig_b   <= norm_sig;
            o.shift   <= '0;
            o.eff_sub <= 1'b0;
            o.cls     <= nxt_cls;
            o.special <= nxt_special;
        end
    end

    // rounding assumes a normalized significand for every normal result
    a_hidden_bit: assert property (@(posedge clk) disable iff (!rst_n)
        (o.valid && (o.cls == CLS_NORMAL)) |-> o.sig_b[`FP_SIG_W-1]);

endmodule

`default_nettype wire
